// File: hdl/apb_bridge_pkg.sv
// Shared widths for the multi-port APB bridge
// Command and response packet structs, APB request and response structs

`default_nettype none

package apb_bridge_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    // APB address and data
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;

    // One byte lane
    localparam int SYMBOL_W = 8;

    // Low address bits that APB never sees, 2 for a 32-bit bus
    localparam int ALIGN_BITS = $clog2(DATA_W / SYMBOL_W);

    // Source and destination IDs
    localparam int ID_W     = 2;

    // ------------------------------------------------------------
    // Packet side
    // ------------------------------------------------------------
    // Command packet from the network
    typedef struct packed {
        logic [ID_W-1:0]   dest_id;
        logic [ID_W-1:0]   src_id;
        logic              write;
        // Write only, no response wanted
        logic              posted;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } cmd_pkt_t;

    // Response packet back to the master, IDs swapped
    typedef struct packed {
        logic [ID_W-1:0]   dest_id;
        logic [ID_W-1:0]   src_id;
        logic              write;
        // Aligned address as seen on APB
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] rdata;
        logic              slverr;
    } rsp_pkt_t;

    // ------------------------------------------------------------
    // APB side
    // ------------------------------------------------------------
    // Master outputs of one port
    typedef struct packed {
        logic [ADDR_W-1:0] paddr;
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    // Slave outputs of one port
    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// File: hdl/apb_bridge_top.sv
// Multi-port APB bridge top level
// Dispatcher, one APB agent per port, response arbiter

`default_nettype none

module apb_bridge_top #(
    // At most 2**ID_W ports
    parameter int NUM_PORTS = 4
) (
    input  wire                           clk,
    input  wire                           reset,

    // ------------------------------------------------------------
    // Command stream
    // ------------------------------------------------------------
    input  wire                           cmd_valid,
    output logic                          cmd_ready,
    input  wire apb_bridge_pkg::cmd_pkt_t cmd_pkt,

    // ------------------------------------------------------------
    // Response stream
    // ------------------------------------------------------------
    output logic                          rsp_valid,
    input  wire                           rsp_ready,
    output apb_bridge_pkg::rsp_pkt_t      rsp_pkt,

    // ------------------------------------------------------------
    // APB ports, one entry per agent
    // ------------------------------------------------------------
    output apb_bridge_pkg::apb_req_t      apb_req [NUM_PORTS],
    input  wire apb_bridge_pkg::apb_rsp_t apb_rsp [NUM_PORTS]
);

    // Dispatcher to agents
    logic [NUM_PORTS-1:0]     port_valid;
    logic [NUM_PORTS-1:0]     port_ready;
    apb_bridge_pkg::cmd_pkt_t port_cmd;

    // Agents to arbiter
    logic [NUM_PORTS-1:0]     agent_rsp_valid;
    logic [NUM_PORTS-1:0]     agent_rsp_ready;
    apb_bridge_pkg::rsp_pkt_t agent_rsp [NUM_PORTS];

    cmd_dispatch #(
        .NUM_PORTS  (NUM_PORTS)
    ) cmd_dispatch_i (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_pkt    (cmd_pkt),
        .port_valid (port_valid),
        .port_ready (port_ready),
        .port_cmd   (port_cmd)
    );

    // One agent per port, all run in parallel
    for (genvar i = 0; i < NUM_PORTS; i++)
    begin : g_port
        apb_port_agent apb_port_agent_i (
            .clk        (clk),
            .reset      (reset),
            .port_valid (port_valid[i]),
            .port_ready (port_ready[i]),
            .port_cmd   (port_cmd),
            .apb_req    (apb_req[i]),
            .apb_rsp    (apb_rsp[i]),
            .rsp_valid  (agent_rsp_valid[i]),
            .rsp_ready  (agent_rsp_ready[i]),
            .rsp_pkt    (agent_rsp[i])
        );
    end

    rsp_arbiter #(
        .NUM_PORTS       (NUM_PORTS)
    ) rsp_arbiter_i (
        .clk             (clk),
        .reset           (reset),
        .agent_rsp_valid (agent_rsp_valid),
        .agent_rsp_ready (agent_rsp_ready),
        .agent_rsp       (agent_rsp),
        .rsp_valid       (rsp_valid),
        .rsp_ready       (rsp_ready),
        .rsp_pkt         (rsp_pkt)
    );

endmodule

`default_nettype wire

// File: hdl/apb_port_agent.sv
// APB master for one port
// IDLE, SETUP, ACCESS, RESPOND state machine with wait states on pready
// Response capture and response packet build with swapped IDs

`default_nettype none

module apb_port_agent (
    input  wire                           clk,
    input  wire                           reset,

    // Command from the dispatcher
    input  wire                           port_valid,
    output logic                          port_ready,
    input  wire apb_bridge_pkg::cmd_pkt_t port_cmd,

    // APB port
    output apb_bridge_pkg::apb_req_t      apb_req,
    input  wire apb_bridge_pkg::apb_rsp_t apb_rsp,

    // Response towards the arbiter
    output logic                          rsp_valid,
    input  wire                           rsp_ready,
    output apb_bridge_pkg::rsp_pkt_t      rsp_pkt
);

    // ------------------------------------------------------------
    // State machine declaration
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        RESPOND
    } state_t;

    state_t state;
    state_t next_state;

    // Accepted command, held for the whole transfer
    apb_bridge_pkg::cmd_pkt_t cmd_reg;

    // Slave response, held until the arbiter takes it
    logic [apb_bridge_pkg::DATA_W-1:0] rdata_reg;
    logic                              slverr_reg;

    // Word address as APB sees it
    logic [apb_bridge_pkg::ADDR_W-1:0] aligned_addr;

    // Posted flag counts on writes only
    logic                              no_response;

    logic                              cmd_accept;
    logic                              apb_done;

    assign aligned_addr = {cmd_reg.addr[apb_bridge_pkg::ADDR_W-1:apb_bridge_pkg::ALIGN_BITS],
                           {apb_bridge_pkg::ALIGN_BITS{1'b0}}};
    assign no_response  = cmd_reg.write && cmd_reg.posted;

    // One command at a time
    assign port_ready   = (state == IDLE);
    assign cmd_accept   = port_valid && port_ready;

    // End of the access phase
    assign apb_done     = (state == ACCESS) && apb_rsp.pready;

    // ------------------------------------------------------------
    // Command and response capture
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (cmd_accept)
        begin
            cmd_reg <= port_cmd;
        end
    end

    // Sample slave data on the last access cycle
    always_ff @(posedge clk)
    begin
        if (apb_done)
        begin
            rdata_reg  <= apb_rsp.prdata;
            slverr_reg <= apb_rsp.pslverr;
        end
    end

    // ------------------------------------------------------------
    // State machine
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                if (cmd_accept)
                    next_state = SETUP;
            end
            // Setup phase lasts exactly one cycle
            SETUP:
                next_state = ACCESS;
            ACCESS:
            begin
                // Wait states while pready is low
                if (apb_rsp.pready)
                    next_state = no_response ? IDLE : RESPOND;
            end
            RESPOND:
            begin
                if (rsp_ready)
                    next_state = IDLE;
            end
            default:
                next_state = IDLE;
        endcase
    end

    // ------------------------------------------------------------
    // APB outputs
    // ------------------------------------------------------------
    // Address, direction and data stay put from SETUP through ACCESS
    assign apb_req.paddr   = aligned_addr;
    assign apb_req.psel    = (state == SETUP) || (state == ACCESS);
    assign apb_req.penable = (state == ACCESS);
    assign apb_req.pwrite  = cmd_reg.write;
    assign apb_req.pwdata  = cmd_reg.wdata;

    // ------------------------------------------------------------
    // Response packet
    // ------------------------------------------------------------
    assign rsp_valid       = (state == RESPOND);

    // IDs swapped so the packet routes back to its master
    assign rsp_pkt.dest_id = cmd_reg.src_id;
    assign rsp_pkt.src_id  = cmd_reg.dest_id;
    assign rsp_pkt.write   = cmd_reg.write;
    assign rsp_pkt.addr    = aligned_addr;
    assign rsp_pkt.rdata   = rdata_reg;
    assign rsp_pkt.slverr  = slverr_reg;

endmodule

`default_nettype wire

// File: hdl/cmd_dispatch.sv
// One-entry command stage
// Routes each held packet to one port agent by its destination ID

`default_nettype none

module cmd_dispatch #(
    parameter int NUM_PORTS = 4
) (
    input  wire                       clk,
    input  wire                       reset,

    // Command stream from outside
    input  wire                       cmd_valid,
    output logic                      cmd_ready,
    input  wire apb_bridge_pkg::cmd_pkt_t cmd_pkt,

    // Towards the port agents
    output logic [NUM_PORTS-1:0]      port_valid,
    input  wire  [NUM_PORTS-1:0]      port_ready,
    output apb_bridge_pkg::cmd_pkt_t  port_cmd
);

    // ------------------------------------------------------------
    // Holding register
    // ------------------------------------------------------------
    logic                     hold_valid;
    apb_bridge_pkg::cmd_pkt_t hold_pkt;

    // Destination exists in this build
    logic                     port_present;
    // Addressed agent takes the packet this cycle
    logic                     sel_ready;
    // Held packet leaves the stage by an offer or a drop
    logic                     hold_taken;

    assign port_present = int'(hold_pkt.dest_id) < NUM_PORTS;

    // One-hot decode of dest_id that stays empty for a missing port
    always_comb
    begin
        port_valid = '0;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            port_valid[i] = hold_valid && (int'(hold_pkt.dest_id) == i);
        end
    end

    assign sel_ready  = |(port_valid & port_ready);

    // A packet for a missing port is dropped without being offered
    assign hold_taken = hold_valid && (!port_present || sel_ready);

    // Ready when empty or when refilled in the cycle it drains
    assign cmd_ready  = !hold_valid || hold_taken;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            hold_valid <= 1'b0;
        end
        else if (cmd_ready)
        begin
            hold_valid <= cmd_valid;
        end
    end

    // Payload register loads on every accepted command
    always_ff @(posedge clk)
    begin
        if (cmd_valid && cmd_ready)
        begin
            hold_pkt <= cmd_pkt;
        end
    end

    // Shared by all agents and qualified by port_valid
    assign port_cmd = hold_pkt;

endmodule

`default_nettype wire

// File: hdl/rsp_arbiter.sv
// Round-robin response arbiter
// Collects agent responses into one registered output stage

`default_nettype none

module rsp_arbiter #(
    parameter int NUM_PORTS = 4
) (
    input  wire                           clk,
    input  wire                           reset,

    // From the port agents
    input  wire  [NUM_PORTS-1:0]          agent_rsp_valid,
    output logic [NUM_PORTS-1:0]          agent_rsp_ready,
    input  wire apb_bridge_pkg::rsp_pkt_t agent_rsp [NUM_PORTS],

    // Response stream to outside
    output logic                          rsp_valid,
    input  wire                           rsp_ready,
    output apb_bridge_pkg::rsp_pkt_t      rsp_pkt
);

    // Pointer needs at least one bit
    localparam int PTR_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    // Highest priority port for the next grant
    logic [PTR_W-1:0]     rr_ptr;

    logic [NUM_PORTS-1:0] grant_vec;
    logic [PTR_W-1:0]     grant_idx;
    logic                 grant_any;

    // Output register free, or emptied this cycle
    logic                 load_en;

    assign load_en = !rsp_valid || rsp_ready;

    // ------------------------------------------------------------
    // Grant search
    // ------------------------------------------------------------
    // First requester at or after the pointer, wrapping around
    always_comb
    begin : grant_search
        int idx;
        grant_vec = '0;
        grant_idx = '0;
        grant_any = 1'b0;
        for (int off = 0; off < NUM_PORTS; off++)
        begin
            idx = (int'(rr_ptr) + off) % NUM_PORTS;
            if (!grant_any && agent_rsp_valid[idx])
            begin
                grant_any      = 1'b1;
                grant_vec[idx] = 1'b1;
                grant_idx      = PTR_W'(idx);
            end
        end
    end

    // Acknowledge only when the packet is really loaded
    assign agent_rsp_ready = load_en ? grant_vec : '0;

    // ------------------------------------------------------------
    // Output stage
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            rsp_valid <= 1'b0;
            rr_ptr    <= '0;
        end
        else if (load_en)
        begin
            rsp_valid <= grant_any;
            // Port after the winner goes first next time
            if (grant_any)
                rr_ptr <= PTR_W'((int'(grant_idx) + 1) % NUM_PORTS);
        end
    end

    // Held stable while the consumer stalls
    always_ff @(posedge clk)
    begin
        if (load_en && grant_any)
        begin
            rsp_pkt <= agent_rsp[grant_idx];
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build the APB bridge testbench with Verilator, run it, and check the log
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_apb_bridge \
    -f verilog.f \
    -Mdir obj_dir -o tb_apb_bridge

./obj_dir/tb_apb_bridge | tee "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi
echo "Simulation passed"

// File: sim/apb_slave_model.sv
// Behavioural APB slave with a word memory
// 0 to 3 random wait states, error region where addr[15:12] is all ones

`default_nettype none

module apb_slave_model (
    input  wire                           clk,
    input  wire                           reset,
    input  wire apb_bridge_pkg::apb_req_t apb_req,
    output apb_bridge_pkg::apb_rsp_t      apb_rsp
);

    // Unwritten words read back as their address XOR this key
    localparam logic [31:0] FILL_KEY = 32'h5A5A_C3C3;

    // Sparse memory, keyed by the aligned address
    logic [apb_bridge_pkg::DATA_W-1:0] mem [logic [apb_bridge_pkg::ADDR_W-1:0]];

    // Wait cycles left in the current access phase
    logic [1:0]                        wait_cnt;
    logic [apb_bridge_pkg::DATA_W-1:0] rdata_q;
    logic                              in_setup;
    logic                              last_access;
    logic                              err_region;

    assign in_setup    = apb_req.psel && !apb_req.penable;
    assign last_access = apb_req.psel && apb_req.penable && (wait_cnt == 2'd0);
    assign err_region  = (apb_req.paddr[15:12] == 4'hF);

    assign apb_rsp.pready  = last_access;
    assign apb_rsp.pslverr = last_access && err_region;
    assign apb_rsp.prdata  = last_access ? rdata_q : '0;

    // Wait count drawn in SETUP, counted down through ACCESS
    always @(posedge clk or posedge reset)
    begin
        if (reset)
            wait_cnt <= 2'd0;
        else if (in_setup)
            wait_cnt <= 2'($urandom_range(0, 3));
        else if (apb_req.psel && apb_req.penable && (wait_cnt != 2'd0))
            wait_cnt <= wait_cnt - 2'd1;
    end

    // Read word fixed in SETUP, the address holds for the whole transfer
    always @(posedge clk)
    begin
        if (in_setup)
        begin
            if (apb_req.pwrite || err_region)
                rdata_q <= '0;
            else if (mem.exists(apb_req.paddr))
                rdata_q <= mem[apb_req.paddr];
            else
                rdata_q <= apb_req.paddr ^ FILL_KEY;
        end
    end

    // Writes land on the last access cycle, never in the error region
    always @(posedge clk)
    begin
        if (last_access && apb_req.pwrite && !err_region)
            mem[apb_req.paddr] = apb_req.pwdata;
    end

endmodule

`default_nettype wire

// File: sim/tb_apb_bridge.sv
// Testbench for the multi-port APB bridge
// Directed and random stimulus, per-port scoreboard, APB protocol assertions

`default_nettype none

module tb_apb_bridge;

    localparam int NUM_PORTS = 3;
    // Unwritten words read back as address XOR this key
    localparam logic [31:0] FILL_KEY = 32'h5A5A_C3C3;

    logic                     clk;
    logic                     reset;
    logic                     cmd_valid;
    logic                     cmd_ready;
    apb_bridge_pkg::cmd_pkt_t cmd_pkt;
    logic                     rsp_valid;
    logic                     rsp_ready;
    apb_bridge_pkg::rsp_pkt_t rsp_pkt;
    apb_bridge_pkg::apb_req_t apb_req [NUM_PORTS];
    apb_bridge_pkg::apb_rsp_t apb_rsp [NUM_PORTS];

    // Expected responses per port and a reference memory keyed by {port, address}
    apb_bridge_pkg::rsp_pkt_t exp_q [NUM_PORTS][$];
    logic [31:0]              exp_mem [logic [33:0]];

    string test_name;
    int    error_count;
    int    test_count;
    int    fail_count;
    int    cmd_count;
    int    present_cmds;
    int    setup_count;
    int    rsp_count;
    int    exp_rsp_count;
    int    cycle_count;
    logic  random_ready;

    apb_bridge_top #(
        .NUM_PORTS (NUM_PORTS)
    ) apb_bridge_top_i (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_pkt   (cmd_pkt),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_pkt   (rsp_pkt),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp)
    );

    function automatic void flag_error(string msg);
        error_count++;
        $display("%s (test %s)", msg, test_name);
    endfunction

    function automatic void check_value(string what, logic [127:0] expected,
                                        logic [127:0] actual);
        assert (expected === actual)
        else
        begin
            error_count++;
            $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what,
                     expected, actual);
        end
    endfunction

    // ------------------------------------------------------------
    // Slaves and per-port APB protocol checks
    // ------------------------------------------------------------
    for (genvar p = 0; p < NUM_PORTS; p++)
    begin : g_port
        apb_slave_model apb_slave_model_i (
            .clk     (clk),
            .reset   (reset),
            .apb_req (apb_req[p]),
            .apb_rsp (apb_rsp[p])
        );

        a_penable_psel: assert property (@(posedge clk) disable iff (reset)
            apb_req[p].penable |-> apb_req[p].psel)
            else flag_error($sformatf("Port %0d drove penable without psel", p));

        // Setup phase of exactly one cycle ahead of penable
        a_setup_first: assert property (@(posedge clk) disable iff (reset)
            $rose(apb_req[p].psel) |-> !apb_req[p].penable ##1 apb_req[p].penable)
            else flag_error($sformatf("Port %0d psel did not lead penable by one cycle", p));

        a_stable: assert property (@(posedge clk) disable iff (reset)
            apb_req[p].psel && $past(apb_req[p].psel) |->
                $stable(apb_req[p].paddr) && $stable(apb_req[p].pwrite) &&
                $stable(apb_req[p].pwdata))
            else flag_error($sformatf("Port %0d changed address or data inside a transfer", p));

        a_aligned: assert property (@(posedge clk) disable iff (reset)
            apb_req[p].psel |-> apb_req[p].paddr[apb_bridge_pkg::ALIGN_BITS-1:0] == '0)
            else flag_error($sformatf("Port %0d put an unaligned address on paddr", p));
    end

    // Response held while the consumer stalls
    a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_pkt))
        else flag_error("Response changed or dropped under back-pressure");

    // ------------------------------------------------------------
    // Clock, back-pressure, monitors and timeout
    // ------------------------------------------------------------
    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(negedge clk)
        rsp_ready = random_ready ? 1'($urandom_range(0, 1)) : 1'b1;

    // One SETUP cycle per APB transfer
    always @(posedge clk)
    begin
        for (int p = 0; p < NUM_PORTS; p++)
            if (!reset && apb_req[p].psel && !apb_req[p].penable)
                setup_count++;
    end

    always @(posedge clk)
    begin : rsp_monitor
        int                       port;
        apb_bridge_pkg::rsp_pkt_t exp_pkt;
        if (!reset && rsp_valid && rsp_ready)
        begin
            port = int'(rsp_pkt.src_id);
            rsp_count++;
            if (port >= NUM_PORTS || exp_q[port].size() == 0)
                flag_error($sformatf("Unexpected response from port %0d", port));
            else
            begin
                exp_pkt = exp_q[port].pop_front();
                check_value($sformatf("response port %0d", port), exp_pkt, rsp_pkt);
            end
        end
    end

    // Limit grows with the traffic issued so far
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > 60 * cmd_count + 1000)
        begin
            $display("Timeout after %0d cycles with %0d commands issued", cycle_count,
                     cmd_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    // Expected response and reference memory update for one accepted command
    function automatic void score_cmd(apb_bridge_pkg::cmd_pkt_t cmd);
        apb_bridge_pkg::rsp_pkt_t rsp;
        logic [31:0]              word_addr;
        logic [33:0]              key;
        if (int'(cmd.dest_id) >= NUM_PORTS)
            return;
        present_cmds++;
        word_addr   = cmd.addr & ~((32'd1 << apb_bridge_pkg::ALIGN_BITS) - 32'd1);
        key         = {cmd.dest_id, word_addr};
        rsp.dest_id = cmd.src_id;
        rsp.src_id  = cmd.dest_id;
        rsp.write   = cmd.write;
        rsp.addr    = word_addr;
        rsp.slverr  = (word_addr[15:12] == 4'hF);
        rsp.rdata   = '0;
        if (!cmd.write && !rsp.slverr)
            rsp.rdata = exp_mem.exists(key) ? exp_mem[key] : (word_addr ^ FILL_KEY);
        if (cmd.write && !rsp.slverr)
            exp_mem[key] = cmd.wdata;
        if (!(cmd.write && cmd.posted))
        begin
            exp_q[cmd.dest_id].push_back(rsp);
            exp_rsp_count++;
        end
    endfunction

    // Called on a falling edge; cmd_ready comes from registers and is settled there
    task automatic send_cmd(input logic [1:0] dest, input logic write, input logic posted,
                            input logic [31:0] addr, input logic [31:0] wdata);
        apb_bridge_pkg::cmd_pkt_t cmd;
        cmd.dest_id = dest;
        cmd.src_id  = 2'($urandom_range(0, 3));
        cmd.write   = write;
        cmd.posted  = posted;
        cmd.addr    = addr;
        cmd.wdata   = wdata;
        cmd_count++;
        cmd_valid = 1'b1;
        cmd_pkt   = cmd;
        while (!cmd_ready)
            @(negedge clk);
        score_cmd(cmd);
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    // Until every response is back and every accepted command has run on APB
    task automatic wait_drain();
        int pending;
        do
        begin
            @(negedge clk);
            pending = (setup_count < present_cmds) ? 1 : 0;
            for (int p = 0; p < NUM_PORTS; p++)
                pending += exp_q[p].size() + int'(apb_req[p].psel);
        end
        while (pending != 0);
    endtask

    task automatic end_test(input int errors_at_start);
        test_count++;
        if (error_count == errors_at_start)
            $display("test %-16s passed", test_name);
        else
        begin
            fail_count++;
            $display("test %-16s failed with %0d errors", test_name,
                     error_count - errors_at_start);
        end
    endtask

    // Normal window with one address in six in the error region
    function automatic logic [31:0] random_addr();
        logic [31:0] base;
        base = ($urandom_range(0, 5) == 0) ? 32'h0000_F000 : 32'h0000_3000;
        return base | (32'($urandom_range(0, 7)) << 2) | 32'($urandom_range(0, 3));
    endfunction

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial
    begin : main
        int errs;
        int rsp_start;
        int setup_start;
        logic [1:0] dest;
        logic       wr;

        void'($urandom(56795));
        reset        = 1'b1;
        cmd_valid    = 1'b0;
        cmd_pkt      = '0;
        rsp_ready    = 1'b0;
        random_ready = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_name = "write_read";
        errs = error_count;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            send_cmd(2'(p), 1'b1, 1'b0, 32'h0000_2000 + 32'(p * 16), $urandom);
            // Same word at another byte offset
            send_cmd(2'(p), 1'b0, 1'b0, 32'h0000_2000 + 32'(p * 16 + $urandom_range(0, 3)), '0);
        end
        wait_drain();
        end_test(errs);

        test_name = "posted_write";
        errs = error_count;
        rsp_start = rsp_count;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            send_cmd(2'(p), 1'b1, 1'b1, 32'h0000_2100, $urandom);
            send_cmd(2'(p), 1'b1, 1'b1, 32'h0000_2104, $urandom);
            send_cmd(2'(p), 1'b0, 1'b0, 32'h0000_2100, '0);
            send_cmd(2'(p), 1'b0, 1'b0, 32'h0000_2104, '0);
        end
        wait_drain();
        check_value("read responses", 2 * NUM_PORTS, rsp_count - rsp_start);
        end_test(errs);

        test_name = "error_region";
        errs = error_count;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            send_cmd(2'(p), 1'b1, 1'b0, 32'h0000_F010, $urandom);
            send_cmd(2'(p), 1'b0, 1'b0, 32'h0001_F024, '0);
            send_cmd(2'(p), 1'b0, 1'b0, 32'h0000_E024, '0);
        end
        wait_drain();
        end_test(errs);

        test_name = "random_traffic";
        errs = error_count;
        random_ready = 1'b1;
        for (int n = 0; n < 200; n++)
        begin
            dest = ($urandom_range(0, 9) == 0) ? 2'd3 : 2'($urandom_range(0, NUM_PORTS - 1));
            wr   = 1'($urandom_range(0, 1));
            // Posted flag also lands on reads, which still answer
            send_cmd(dest, wr, ($urandom_range(0, 2) == 0), random_addr(), $urandom);
            if ($urandom_range(0, 3) == 0)
                repeat ($urandom_range(1, 4)) @(negedge clk);
        end
        wait_drain();
        random_ready = 1'b0;
        end_test(errs);

        test_name = "missing_port";
        errs = error_count;
        rsp_start = rsp_count;
        setup_start = setup_count;
        send_cmd(2'd3, 1'b1, 1'b0, 32'h0000_2000, $urandom);
        send_cmd(2'd3, 1'b0, 1'b0, 32'h0000_2000, '0);
        send_cmd(2'd3, 1'b1, 1'b1, 32'h0000_2004, $urandom);
        // Stage drains in order so this read trails the dropped commands
        send_cmd(2'd0, 1'b0, 1'b0, 32'h0000_2000, '0);
        wait_drain();
        check_value("APB transfers", 1, setup_count - setup_start);
        check_value("responses", 1, rsp_count - rsp_start);
        end_test(errs);

        check_value("total responses", exp_rsp_count, rsp_count);
        check_value("total transfers", present_cmds, setup_count);
        $display("tests %0d, failed %0d, errors %0d, commands %0d, responses %0d",
                 test_count, fail_count, error_count, cmd_count, rsp_count);
        if (error_count == 0 && fail_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
hdl/apb_bridge_pkg.sv
hdl/cmd_dispatch.sv
hdl/apb_port_agent.sv
hdl/rsp_arbiter.sv
hdl/apb_bridge_top.sv
sim/apb_slave_model.sv
sim/tb_apb_bridge.sv
